/* design/adv_timer.sv */
/* Advanced timer
   Active config and run flag, counter and two compare channels */

`timescale 1ns/1ps
`default_nettype none

module adv_timer (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  timer_pkg::timer_cfg_t cfg_i,   // Shadow config
   input  timer_pkg::timer_cmd_t cmd_i,
   output timer_pkg::cnt_t       count_o,
   output logic                  end_o,
   output logic [1:0]            pwm_o
);

   timer_pkg::timer_cfg_t act_cfg_q;
   logic                  run_q;
   logic                  cnt_step;
   logic                  cnt_end_p;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         act_cfg_q <= '0;
         run_q     <= 1'b0;
      end else begin
         if (cmd_i.update) begin
            act_cfg_q <= cfg_i; // Shadow becomes live
         end
         if (cmd_i.stop) begin
            run_q <= 1'b0; // Stop wins over start
         end else if (cmd_i.start) begin
            run_q <= 1'b1;
         end
      end
   end

   timer_counter u_cnt (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .enable_i  (run_q),
      .rst_cnt_i (cmd_i.rst),
      .cfg_i     (act_cfg_q),
      .count_o   (count_o),
      .step_o    (cnt_step),
      .end_o     (cnt_end_p)
   );

   timer_compare u_cmp0 (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .step_i  (cnt_step),
      .end_i   (cnt_end_p),
      .count_i (count_o),
      .comp_i  (act_cfg_q.comp0),
      .op_i    (act_cfg_q.op0),
      .pwm_o   (pwm_o[0])
   );

   timer_compare u_cmp1 (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .step_i  (cnt_step),
      .end_i   (cnt_end_p),
      .count_i (count_o),
      .comp_i  (act_cfg_q.comp1),
      .op_i    (act_cfg_q.op1),
      .pwm_o   (pwm_o[1])
   );

   assign end_o = cnt_end_p;

endmodule

`default_nettype wire

/* design/apb_adv_timer_top.sv */
/* APB advanced timer subsystem
   Register block driving NUM_TIMERS timers with two PWM outputs each */

`timescale 1ns/1ps
`default_nettype none

module apb_adv_timer_top #(
   parameter int NUM_TIMERS = 2
) (
   input  logic                    clk_i,
   input  logic                    reset_i,
   input  logic                    psel_i,
   input  logic                    penable_i,
   input  logic                    pwrite_i,
   input  timer_pkg::addr_t        paddr_i,
   input  timer_pkg::data_t        pwdata_i,
   output timer_pkg::data_t        prdata_o,
   output logic                    pslverr_o,
   output logic [2*NUM_TIMERS-1:0] pwm_o,    // Timer i on bits 2i+1:2i
   output logic [NUM_TIMERS-1:0]   events_o
);

   timer_pkg::timer_cfg_t tmr_cfg [NUM_TIMERS];
   timer_pkg::timer_cmd_t tmr_cmd [NUM_TIMERS];
   timer_pkg::cnt_t       tmr_count [NUM_TIMERS];
   logic [NUM_TIMERS-1:0] tmr_end;

   apb_timer_regs #(
      .NUM_TIMERS (NUM_TIMERS)
   ) u_regs (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .pslverr_o (pslverr_o),
      .cfg_o     (tmr_cfg),
      .cmd_o     (tmr_cmd),
      .count_i   (tmr_count),
      .end_i     (tmr_end),
      .events_o  (events_o)
   );

   for (genvar i = 0; i < NUM_TIMERS; i++) begin : gen_timer
      adv_timer u_tim (
         .clk_i   (clk_i),
         .reset_i (reset_i),
         .cfg_i   (tmr_cfg[i]),
         .cmd_i   (tmr_cmd[i]),
         .count_o (tmr_count[i]),
         .end_o   (tmr_end[i]),
         .pwm_o   (pwm_o[2*i +: 2])
      );
   end

endmodule

`default_nettype wire

/* design/apb_timer_regs.sv */
/* APB timer register block
   Zero wait state slave with shadow config, command pulses and event status */

`timescale 1ns/1ps
`default_nettype none

module apb_timer_regs #(
   parameter int NUM_TIMERS = 2 // Up to 4 before the timer blocks reach REG_EVENT
) (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  psel_i,
   input  logic                  penable_i,
   input  logic                  pwrite_i,
   input  timer_pkg::addr_t      paddr_i,
   input  timer_pkg::data_t      pwdata_i,
   output timer_pkg::data_t      prdata_o,
   output logic                  pslverr_o,
   output timer_pkg::timer_cfg_t cfg_o [NUM_TIMERS],
   output timer_pkg::timer_cmd_t cmd_o [NUM_TIMERS],
   input  timer_pkg::cnt_t       count_i [NUM_TIMERS],
   input  logic [NUM_TIMERS-1:0] end_i,
   output logic [NUM_TIMERS-1:0] events_o
);

   timer_pkg::timer_cfg_t shadow_q [NUM_TIMERS];
   timer_pkg::timer_cmd_t cmd_q [NUM_TIMERS];
   logic [NUM_TIMERS-1:0] events_q;
   logic [NUM_TIMERS-1:0] ev_clr;
   logic [NUM_TIMERS-1:0] cmd_any;
   logic [2:0]            tmr_idx;
   timer_pkg::addr_t      off;
   logic                  access;
   logic                  wr_en;
   logic                  rd_en;
   logic                  in_timer;
   logic                  is_event;
   logic                  off_ok;
   logic                  addr_ok;
   timer_pkg::timer_cfg_t sel_cfg;
   timer_pkg::cnt_t       sel_cnt;
   timer_pkg::data_t      rdata;

   // Address decode
   assign tmr_idx  = paddr_i[7:5];
   assign off      = timer_pkg::addr_t'(paddr_i[4:0]);
   assign in_timer = paddr_i < timer_pkg::addr_t'(NUM_TIMERS * timer_pkg::TIMER_STRIDE);
   assign is_event = (paddr_i == timer_pkg::REG_EVENT);
   assign off_ok   = (off == timer_pkg::REG_CMD) || (off == timer_pkg::REG_CFG) ||
                     (off == timer_pkg::REG_TH)  || (off == timer_pkg::REG_CH0) ||
                     (off == timer_pkg::REG_CH1) || (off == timer_pkg::REG_COUNTER);
   assign addr_ok  = (in_timer && off_ok) || is_event;

   assign access    = psel_i && penable_i;
   assign wr_en     = access && pwrite_i && addr_ok;
   assign rd_en     = access && !pwrite_i;
   assign pslverr_o = access && !addr_ok;

   assign ev_clr = (wr_en && is_event) ? pwdata_i[NUM_TIMERS-1:0] : '0;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int i = 0; i < NUM_TIMERS; i++) begin
            shadow_q[i] <= '0;
            cmd_q[i]    <= '0;
         end
         events_q <= '0;
      end else begin
         for (int i = 0; i < NUM_TIMERS; i++) begin
            cmd_q[i] <= '0; // Pulses last one cycle
            if (wr_en && in_timer && (tmr_idx == 3'(i))) begin
               case (off)
                  timer_pkg::REG_CMD: begin
                     cmd_q[i].start  <= pwdata_i[timer_pkg::CMD_START_BIT];
                     cmd_q[i].stop   <= pwdata_i[timer_pkg::CMD_STOP_BIT];
                     cmd_q[i].rst    <= pwdata_i[timer_pkg::CMD_RST_BIT];
                     cmd_q[i].update <= pwdata_i[timer_pkg::CMD_UPDATE_BIT];
                  end
                  timer_pkg::REG_CFG: begin
                     shadow_q[i].presc    <= pwdata_i[7:0];
                     shadow_q[i].sawtooth <= pwdata_i[8];
                  end
                  timer_pkg::REG_TH: begin
                     shadow_q[i].cnt_start <= pwdata_i[15:0];
                     shadow_q[i].cnt_end   <= pwdata_i[31:16];
                  end
                  timer_pkg::REG_CH0: begin
                     shadow_q[i].comp0 <= pwdata_i[15:0];
                     shadow_q[i].op0   <= timer_pkg::comp_op_e'(pwdata_i[18:16]);
                  end
                  timer_pkg::REG_CH1: begin
                     shadow_q[i].comp1 <= pwdata_i[15:0];
                     shadow_q[i].op1   <= timer_pkg::comp_op_e'(pwdata_i[18:16]);
                  end
                  default: ; // Counter is read only
               endcase
            end
         end
         events_q <= (events_q & ~ev_clr) | end_i; // A new event beats the clear
      end
   end

   // Timer selected for readback
   always_comb begin
      sel_cfg = shadow_q[0];
      sel_cnt = count_i[0];
      for (int i = 0; i < NUM_TIMERS; i++) begin
         if (tmr_idx == 3'(i)) begin
            sel_cfg = shadow_q[i];
            sel_cnt = count_i[i];
         end
      end
   end

   always_comb begin
      rdata = '0;
      if (is_event) begin
         rdata = timer_pkg::data_t'(events_q);
      end else if (in_timer) begin
         case (off)
            timer_pkg::REG_CFG:     rdata = {23'b0, sel_cfg.sawtooth, sel_cfg.presc};
            timer_pkg::REG_TH:      rdata = {sel_cfg.cnt_end, sel_cfg.cnt_start};
            timer_pkg::REG_CH0:     rdata = {13'b0, sel_cfg.op0, sel_cfg.comp0};
            timer_pkg::REG_CH1:     rdata = {13'b0, sel_cfg.op1, sel_cfg.comp1};
            timer_pkg::REG_COUNTER: rdata = {16'b0, sel_cnt};
            default:                rdata = '0; // CMD reads as zero
         endcase
      end
   end

   assign prdata_o = rd_en ? rdata : '0;

   always_comb begin
      for (int i = 0; i < NUM_TIMERS; i++) begin
         cmd_any[i] = |cmd_q[i];
      end
   end

   assign cfg_o    = shadow_q;
   assign cmd_o    = cmd_q;
   assign events_o = events_q;

   // One CMD write addresses one timer
   a_cmd_one_timer: assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(cmd_any));

endmodule

`default_nettype wire

/* design/timer_compare.sv */
/* Timer compare channel
   Applies the match and end of period actions to a registered PWM output */

`timescale 1ns/1ps
`default_nettype none

module timer_compare (
   input  logic                clk_i,
   input  logic                reset_i,
   input  logic                step_i,
   input  logic                end_i,
   input  timer_pkg::cnt_t     count_i,
   input  timer_pkg::cnt_t     comp_i,
   input  timer_pkg::comp_op_e op_i,
   output logic                pwm_o
);

   logic match;
   logic end_act;

   assign match   = step_i && (count_i == comp_i);
   // Only the two period ops have an end half
   assign end_act = end_i &&
                    ((op_i == timer_pkg::OP_SET_CLR) || (op_i == timer_pkg::OP_CLR_SET));

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         pwm_o <= 1'b0;
      end else if (end_act) begin
         pwm_o <= (op_i == timer_pkg::OP_CLR_SET); // End beats a match on the same step
      end else if (match) begin
         case (op_i)
            timer_pkg::OP_SET:     pwm_o <= 1'b1;
            timer_pkg::OP_TOGGLE:  pwm_o <= ~pwm_o;
            timer_pkg::OP_CLEAR:   pwm_o <= 1'b0;
            timer_pkg::OP_SET_CLR: pwm_o <= 1'b1;
            timer_pkg::OP_CLR_SET: pwm_o <= 1'b0;
            default:               pwm_o <= pwm_o; // Unused encodings hold
         endcase
      end
   end

   // Output moves only in the cycle after a counter step
   a_pwm_after_step: assert property (@(posedge clk_i) disable iff (reset_i)
      !$stable(pwm_o) |-> $past(step_i));

endmodule

`default_nettype wire

/* design/timer_counter.sv */
/* Timer counter
   Prescaler and 16-bit counter in sawtooth or up-down mode with end of period pulse */

`timescale 1ns/1ps
`default_nettype none

module timer_counter (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  enable_i,
   input  logic                  rst_cnt_i,
   input  timer_pkg::timer_cfg_t cfg_i,
   output timer_pkg::cnt_t       count_o,
   output logic                  step_o,
   output logic                  end_o
);

   timer_pkg::presc_t presc_q;
   timer_pkg::cnt_t   count_q;
   timer_pkg::cnt_t   cnt_inc;
   timer_pkg::cnt_t   cnt_dec;
   logic              dir_down_q; // Up-down mode only
   logic              tick;
   logic              cfg_ok;
   logic              in_range;

   // Greater-or-equal so a smaller presc after update does not wait for a wrap
   assign tick    = enable_i && (presc_q >= cfg_i.presc);
   assign cnt_inc = count_q + 16'd1;
   assign cnt_dec = count_q - 16'd1;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         presc_q    <= '0;
         count_q    <= '0;
         dir_down_q <= 1'b0;
         step_o     <= 1'b0;
         end_o      <= 1'b0;
      end else if (rst_cnt_i) begin
         presc_q    <= '0;
         count_q    <= cfg_i.cnt_start;
         dir_down_q <= 1'b0;
         step_o     <= 1'b0;
         end_o      <= 1'b0;
      end else begin
         step_o <= tick; // Pulse lines up with the new count value
         end_o  <= 1'b0;
         if (enable_i) begin
            presc_q <= tick ? '0 : presc_q + 8'd1;
         end
         if (tick) begin
            if (cfg_i.sawtooth) begin
               dir_down_q <= 1'b0;
               if (count_q == cfg_i.cnt_end) begin
                  count_q <= cfg_i.cnt_start; // Wrap closes the period
                  end_o   <= 1'b1;
               end else begin
                  count_q <= cnt_inc;
               end
            end else if (!dir_down_q) begin
               if (count_q == cfg_i.cnt_end) begin
                  // Start equal to end, nowhere to go
                  count_q <= cfg_i.cnt_start;
                  end_o   <= 1'b1;
               end else begin
                  count_q    <= cnt_inc;
                  dir_down_q <= (cnt_inc == cfg_i.cnt_end); // Turn on landing
               end
            end else begin
               count_q <= cnt_dec;
               if (cnt_dec == cfg_i.cnt_start) begin
                  dir_down_q <= 1'b0;
                  end_o      <= 1'b1; // Period ends at the bottom
               end
            end
         end
      end
   end

   assign count_o = count_q;

   assign cfg_ok   = (cfg_i.cnt_start <= cfg_i.cnt_end);
   assign in_range = (count_q >= cfg_i.cnt_start) && (count_q <= cfg_i.cnt_end);

   // Once inside a valid window the counter stays there until the window moves
   a_cnt_in_range: assert property (@(posedge clk_i) disable iff (reset_i)
      (enable_i && cfg_ok && in_range) |=> (in_range || !$stable(cfg_i)));

endmodule

`default_nettype wire

/* design/timer_pkg.sv */
/* Advanced timer package
   Counter and bus widths, compare actions, register map and config structs */

`default_nettype none

package timer_pkg;

   typedef logic [15:0] cnt_t;   // Counter, thresholds and compare values
   typedef logic [7:0]  presc_t; // Counter moves once every presc+1 enabled cycles
   typedef logic [7:0]  addr_t;
   typedef logic [31:0] data_t;

   // Action applied to the PWM output of one compare channel
   typedef enum logic [2:0] {
      OP_SET     = 3'd0, // Set on match
      OP_TOGGLE  = 3'd1, // Toggle on match
      OP_CLEAR   = 3'd2, // Clear on match
      OP_SET_CLR = 3'd3, // Set on match, clear at end of period
      OP_CLR_SET = 3'd4  // Clear on match, set at end of period
   } comp_op_e;

   typedef struct packed {
      presc_t   presc;
      logic     sawtooth;  // 1 sawtooth, 0 up-down
      cnt_t     cnt_start;
      cnt_t     cnt_end;
      cnt_t     comp0;
      comp_op_e op0;
      cnt_t     comp1;
      comp_op_e op1;
   } timer_cfg_t;

   // One-cycle command pulses towards a timer
   typedef struct packed {
      logic start;
      logic stop;
      logic rst;
      logic update;
   } timer_cmd_t;

   // Register map, per timer block at index * TIMER_STRIDE
   localparam addr_t TIMER_STRIDE = 8'h20;
   localparam addr_t REG_CMD      = 8'h00;
   localparam addr_t REG_CFG      = 8'h04; // presc 7:0, sawtooth 8
   localparam addr_t REG_TH       = 8'h08; // start 15:0, end 31:16
   localparam addr_t REG_CH0      = 8'h0C; // value 15:0, op 18:16
   localparam addr_t REG_CH1      = 8'h10;
   localparam addr_t REG_COUNTER  = 8'h14; // Read only
   localparam addr_t REG_EVENT    = 8'h80; // Write 1 to clear

   // Bit positions in a REG_CMD write
   localparam int CMD_START_BIT  = 0;
   localparam int CMD_STOP_BIT   = 1;
   localparam int CMD_RST_BIT    = 2;
   localparam int CMD_UPDATE_BIT = 3;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the APB advanced timer testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module tb_apb_adv_timer -o sim_tb; then
   echo "Verilator build failed"
   exit 1
fi

sim_out="$(./obj_dir/sim_tb)"
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "ALL CHECKS PASSED" <<< "$sim_out"; then
   exit 0
fi
echo "Pass message not found"
exit 1

/* tb.f */
design/timer_pkg.sv
design/timer_counter.sv
design/timer_compare.sv
design/adv_timer.sv
design/apb_timer_regs.sv
design/apb_adv_timer_top.sv
verification/tb_apb_adv_timer.sv

/* verification/tb_apb_adv_timer.sv */
/* APB advanced timer testbench
   Cycle model of every timer, checked against pwm_o, events_o and bus reads */

`timescale 1ns/1ps
`default_nettype none

module tb_apb_adv_timer;

   localparam int NUM_TIMERS = 2;

   typedef struct packed {
      timer_pkg::timer_cfg_t shadow;
      timer_pkg::timer_cfg_t act;
      timer_pkg::timer_cmd_t cmd;   // Pulses seen by the timer this cycle
      logic                  run;
      timer_pkg::presc_t     presc;
      timer_pkg::cnt_t       cnt;
      logic                  down;  // Falling half of up-down mode
      logic                  step;
      logic                  endp;
      logic [1:0]            pwm;
      logic                  ev;
   } model_t;

   logic                    clk_i;
   logic                    reset_i;
   logic                    psel_i;
   logic                    penable_i;
   logic                    pwrite_i;
   timer_pkg::addr_t        paddr_i;
   timer_pkg::data_t        pwdata_i;
   timer_pkg::data_t        prdata_o;
   logic                    pslverr_o;
   logic [2*NUM_TIMERS-1:0] pwm_o;
   logic [NUM_TIMERS-1:0]   events_o;

   model_t                mdl [NUM_TIMERS];
   timer_pkg::cnt_t       cnt_snap;   // Model counter at the last read
   logic [NUM_TIMERS-1:0] ev_snap;    // Model event bits at the last read
   int                    seed = 32'h578a9ef6;
   int                    value_errors = 0;
   int                    cmp_errors = 0;
   int                    timeout_errors = 0;

   apb_adv_timer_top #(
      .NUM_TIMERS (NUM_TIMERS)
   ) u_dut (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .pslverr_o (pslverr_o),
      .pwm_o     (pwm_o),
      .events_o  (events_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   function automatic logic pwm_next(input logic cur, input model_t m, input timer_pkg::cnt_t comp,
                                     input timer_pkg::comp_op_e op);
      if (m.endp && op == timer_pkg::OP_SET_CLR) return 1'b0; // End half wins
      if (m.endp && op == timer_pkg::OP_CLR_SET) return 1'b1;
      if (m.step && m.cnt == comp) begin
         case (op)
            timer_pkg::OP_SET, timer_pkg::OP_SET_CLR:   return 1'b1;
            timer_pkg::OP_TOGGLE:                       return ~cur;
            timer_pkg::OP_CLEAR, timer_pkg::OP_CLR_SET: return 1'b0;
            default:                                    return cur;
         endcase
      end
      return cur;
   endfunction

   // One clock of a timer, its register slice and its event bit
   function automatic model_t model_step(input model_t m, input logic hit, input logic [4:0] off,
                                         input timer_pkg::data_t wd, input logic clr);
      model_t n;
      logic   tick;
      n      = m;
      n.cmd  = '0;
      n.step = 1'b0;
      n.endp = 1'b0;
      if (hit) begin
         case (off)
            5'h00: begin
               n.cmd.start  = wd[0];
               n.cmd.stop   = wd[1];
               n.cmd.rst    = wd[2];
               n.cmd.update = wd[3];
            end
            5'h04: {n.shadow.sawtooth, n.shadow.presc} = wd[8:0];
            5'h08: {n.shadow.cnt_end, n.shadow.cnt_start} = wd;
            5'h0C: begin
               n.shadow.comp0 = wd[15:0];
               n.shadow.op0   = timer_pkg::comp_op_e'(wd[18:16]);
            end
            5'h10: begin
               n.shadow.comp1 = wd[15:0];
               n.shadow.op1   = timer_pkg::comp_op_e'(wd[18:16]);
            end
            default: ;
         endcase
      end
      if (m.cmd.update) n.act = m.shadow;
      if (m.cmd.stop) n.run = 1'b0;
      else if (m.cmd.start) n.run = 1'b1;
      if (m.cmd.rst) begin
         n.presc = '0;
         n.cnt   = m.act.cnt_start;
         n.down  = 1'b0;
      end else begin
         tick   = m.run && (m.presc >= m.act.presc);
         n.step = tick;
         if (m.run) n.presc = tick ? 8'd0 : m.presc + 8'd1;
         if (tick && m.act.sawtooth) begin
            n.down = 1'b0;
            n.endp = (m.cnt == m.act.cnt_end);
            n.cnt  = n.endp ? m.act.cnt_start : m.cnt + 16'd1;
         end else if (tick && !m.down) begin
            n.cnt  = m.cnt + 16'd1;
            n.down = (n.cnt == m.act.cnt_end); // Turn at the top
         end else if (tick) begin
            n.cnt  = m.cnt - 16'd1;
            n.endp = (n.cnt == m.act.cnt_start);
            n.down = !n.endp;
         end
      end
      n.pwm[0] = pwm_next(m.pwm[0], m, m.act.comp0, m.act.op0);
      n.pwm[1] = pwm_next(m.pwm[1], m, m.act.comp1, m.act.op1);
      n.ev     = (m.ev && !clr) || m.endp;
      return n;
   endfunction

   always @(posedge clk_i) begin
      for (int i = 0; i < NUM_TIMERS; i++) begin
         if (reset_i) begin
            mdl[i] = '0;
         end else begin
            mdl[i] = model_step(mdl[i],
               psel_i && penable_i && pwrite_i && (int'(paddr_i) < NUM_TIMERS * 32) &&
               (int'(paddr_i[7:5]) == i), paddr_i[4:0], pwdata_i,
               psel_i && penable_i && pwrite_i && (paddr_i == timer_pkg::REG_EVENT) && pwdata_i[i]);
         end
      end
   end

   // Outputs settle well before the falling edge
   always @(negedge clk_i) begin
      if (!reset_i) begin
         for (int i = 0; i < NUM_TIMERS; i++) begin
            assert (pwm_o[2*i +: 2] == mdl[i].pwm) else begin
               $display("Error: %0t pwm_o[%0d+:2] expected %b got %b",
                        $time, 2 * i, mdl[i].pwm, pwm_o[2*i +: 2]);
               cmp_errors++;
            end
            assert (events_o[i] == mdl[i].ev) else begin
               $display("Error: %0t events_o[%0d] expected %b got %b",
                        $time, i, mdl[i].ev, events_o[i]);
               cmp_errors++;
            end
         end
      end
   end

   function automatic timer_pkg::addr_t reg_addr(input int t, input timer_pkg::addr_t off);
      return timer_pkg::addr_t'(t * 32) + off;
   endfunction

   function automatic logic addr_mapped(input timer_pkg::addr_t a);
      logic [4:0] off;
      off = a[4:0];
      if (a == timer_pkg::REG_EVENT) return 1'b1;
      return (int'(a) < NUM_TIMERS * 32) && (off <= 5'h14) && (off[1:0] == 2'b00);
   endfunction

   task automatic check_slverr(input timer_pkg::addr_t a);
      logic exp;
      exp = !addr_mapped(a);
      assert (pslverr_o == exp) else begin
         $display("Error: %0t pslverr_o at %h expected %b got %b", $time, a, exp, pslverr_o);
         value_errors++;
      end
   endtask

   task automatic apb_write(input timer_pkg::addr_t a, input timer_pkg::data_t d);
      @(posedge clk_i);
      psel_i    <= 1'b1;
      penable_i <= 1'b0;
      pwrite_i  <= 1'b1;
      paddr_i   <= a;
      pwdata_i  <= d;
      @(posedge clk_i);
      penable_i <= 1'b1;
      @(negedge clk_i);
      check_slverr(a);
      @(posedge clk_i);
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
      pwrite_i  <= 1'b0;
   endtask

   task automatic apb_read(input timer_pkg::addr_t a, output timer_pkg::data_t d);
      int t;
      @(posedge clk_i);
      psel_i    <= 1'b1;
      penable_i <= 1'b0;
      pwrite_i  <= 1'b0;
      paddr_i   <= a;
      @(posedge clk_i);
      penable_i <= 1'b1;
      @(negedge clk_i);
      d = prdata_o;
      t = int'(a[7:5]);
      if (t < NUM_TIMERS) cnt_snap = mdl[t].cnt;
      for (int i = 0; i < NUM_TIMERS; i++) begin
         ev_snap[i] = mdl[i].ev;
      end
      check_slverr(a);
      @(posedge clk_i);
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
   endtask

   task automatic check_counter(input int t, output timer_pkg::data_t d);
      apb_read(reg_addr(t, timer_pkg::REG_COUNTER), d);
      assert (d == {16'b0, cnt_snap}) else begin
         $display("Error: %0t REG_COUNTER[%0d] expected %h got %h", $time, t, cnt_snap, d);
         value_errors++;
      end
   endtask

   task automatic wait_event(input int t, input int max_cycles);
      int n;
      n = 0;
      @(negedge clk_i);
      while (!events_o[t] && n < max_cycles) begin
         @(negedge clk_i);
         n++;
      end
      assert (events_o[t]) else begin
         $display("Timeout: no event from timer %0d within %0d cycles", t, max_cycles);
         timeout_errors++;
      end
   endtask

   task automatic clear_event(input int t);
      apb_write(timer_pkg::REG_EVENT, timer_pkg::data_t'(1) << t);
   endtask

   // Stop, load all shadows, update, then restart from cnt_start
   task automatic config_timer(input int t, input int presc, input logic saw, input int cs,
                               input int ce, input int c0, input logic [2:0] op0,
                               input int c1, input logic [2:0] op1);
      apb_write(reg_addr(t, timer_pkg::REG_CMD), 32'h2);
      apb_write(reg_addr(t, timer_pkg::REG_CFG), {23'b0, saw, timer_pkg::presc_t'(presc)});
      apb_write(reg_addr(t, timer_pkg::REG_TH), {timer_pkg::cnt_t'(ce), timer_pkg::cnt_t'(cs)});
      apb_write(reg_addr(t, timer_pkg::REG_CH0), {13'b0, op0, timer_pkg::cnt_t'(c0)});
      apb_write(reg_addr(t, timer_pkg::REG_CH1), {13'b0, op1, timer_pkg::cnt_t'(c1)});
      apb_write(reg_addr(t, timer_pkg::REG_CMD), 32'h8); // Update
      apb_write(reg_addr(t, timer_pkg::REG_CMD), 32'h5); // Rst and start
   endtask

   function automatic int rnd(input int max);
      int r;
      r = $random(seed);
      return (r & 32'h7fffffff) % max;
   endfunction

   task automatic random_timer(input int t);
      int cs;
      int span;
      cs   = rnd(200);
      span = rnd(40) + 1;
      config_timer(t, rnd(4), 1'(rnd(2)), cs, cs + span, cs + rnd(span + 1), 3'(rnd(5)),
                   cs + rnd(span + 1), 3'(rnd(5)));
   endtask

   initial begin
      timer_pkg::data_t d;
      timer_pkg::cnt_t  frozen;
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
      pwrite_i  <= 1'b0;
      paddr_i   <= '0;
      pwdata_i  <= '0;
      reset_i   <= 1'b1;
      repeat (10) @(posedge clk_i);
      reset_i <= 1'b0;

      // Sawtooth with prescaler 0 then 3
      config_timer(0, 0, 1'b1, 2, 9, 4, timer_pkg::OP_TOGGLE, 7, timer_pkg::OP_SET_CLR);
      wait_event(0, 100);
      repeat (3) check_counter(0, d);
      clear_event(0);
      config_timer(0, 3, 1'b1, 2, 9, 4, timer_pkg::OP_SET, 9, timer_pkg::OP_CLR_SET);
      wait_event(0, 200);
      repeat (3) check_counter(0, d);

      // Up-down, two full periods
      config_timer(0, 1, 1'b0, 5, 12, 12, timer_pkg::OP_TOGGLE, 5, timer_pkg::OP_SET_CLR);
      for (int k = 0; k < 2; k++) begin
         clear_event(0);
         wait_event(0, 200);
         check_counter(0, d);
      end

      // Every op on both channels, compare at cnt_start meets the end step
      for (int op = 0; op < 5; op++) begin
         config_timer(0, 0, 1'b1, 3, 10, 3, 3'(op), 6, 3'((op + 2) % 5));
         config_timer(1, 0, 1'b0, 3, 10, 10, 3'(op), 3, 3'(4 - op));
         repeat (60) @(posedge clk_i);
      end

      // Shadow holds until update, stop freezes, rst reloads
      config_timer(0, 0, 1'b1, 0, 20, 10, timer_pkg::OP_TOGGLE, 15, timer_pkg::OP_SET);
      apb_write(reg_addr(0, timer_pkg::REG_TH), {16'd8, 16'd5});
      repeat (60) @(posedge clk_i);
      check_counter(0, d);
      apb_read(reg_addr(0, timer_pkg::REG_TH), d);
      assert (d == {16'd8, 16'd5}) else begin
         $display("Error: %0t REG_TH expected %h got %h", $time, {16'd8, 16'd5}, d);
         value_errors++;
      end
      apb_write(reg_addr(0, timer_pkg::REG_CMD), 32'h2);
      check_counter(0, d);
      frozen = cnt_snap; // Model count once stopped
      repeat (10) @(posedge clk_i);
      check_counter(0, d);
      assert (d == {16'b0, frozen}) else begin
         $display("Error: %0t REG_COUNTER after stop expected %h got %h", $time, frozen, d);
         value_errors++;
      end
      apb_write(reg_addr(0, timer_pkg::REG_CMD), 32'h8);
      apb_write(reg_addr(0, timer_pkg::REG_CMD), 32'h4);
      check_counter(0, d);
      assert (d == 32'd5) else begin
         $display("Error: %0t REG_COUNTER after rst expected %h got %h", $time, 32'd5, d);
         value_errors++;
      end
      apb_write(reg_addr(0, timer_pkg::REG_CMD), 32'h1);

      // Write 1 to clear and slave errors
      wait_event(0, 200);
      clear_event(0);
      apb_read(8'h18, d);
      apb_read(8'h84, d);
      apb_write(8'h40, 32'hffff_ffff); // Beyond the last timer
      apb_read(timer_pkg::REG_EVENT, d);
      assert (d == timer_pkg::data_t'(ev_snap)) else begin
         $display("Error: %0t REG_EVENT expected %h got %h", $time, ev_snap, d);
         value_errors++;
      end

      // Random configs on both timers at once
      random_timer(0);
      random_timer(1);
      repeat (2000) @(posedge clk_i);
      check_counter(0, d);
      check_counter(1, d);

      $display("Errors: %0d value, %0d compare, %0d timeout",
               value_errors, cmp_errors, timeout_errors);
      if (value_errors == 0 && cmp_errors == 0 && timeout_errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
